// File: coeff_regs.sv
/*
  Host side bank of four signed coefficients plus the pending-set flag.
  Host writes land immediately. The bank is not double buffered, so writes
  made while a set is being loaded may be picked up part way.
  A new_coefficient_set pulse wins over the clear from the final load.
*/
module coeff_regs (
  input  logic                                      clk,
  input  logic                                      n_reset,
  input  fir_types_pkg::coeff_write_t               host_write,
  input  logic                                      new_coefficient_set,
  input  logic                                      load_coeff,
  input  fir_types_pkg::coeff_num_t                 coefficient_num,
  output logic                                      set_pending,
  output logic signed [fir_types_pkg::COEFF_W-1:0]  coeff_value
);

  logic signed [fir_types_pkg::COEFF_W-1:0] coeff_bank [fir_types_pkg::NUM_TAPS];
  logic                                     last_load;

  assign last_load = load_coeff && (coefficient_num == 2'd3);

  always_ff @(posedge clk, negedge n_reset) begin
    if (!n_reset) begin
      for (int i = 0; i < fir_types_pkg::NUM_TAPS; i++) begin
        coeff_bank[i] <= '0;
      end
    end else if (host_write.wr) begin
      coeff_bank[host_write.idx] <= host_write.value;
    end
  end

  // pending flag, host pulse has priority
  always_ff @(posedge clk, negedge n_reset) begin
    if (!n_reset) begin
      set_pending <= 1'b0;
    end else if (new_coefficient_set) begin
      set_pending <= 1'b1;
    end else if (last_load) begin
      set_pending <= 1'b0;
    end
  end

  assign coeff_value = coeff_bank[coefficient_num];  // read mux

endmodule

// File: coefficient_loader.sv
/*
  Steps a coefficient set into the filter, numbers 0 to 3 in order.
  new_coefficient_set is taken as a level. It must drop after the load
  of number 3, or a second pass starts.
  coefficient_num stays stable from the load pulse until modwait is seen low.
*/
module coefficient_loader (
  input  logic                      clk,
  input  logic                      n_reset,
  input  logic                      new_coefficient_set,
  input  logic                      modwait,
  output logic                      load_coeff,
  output fir_types_pkg::coeff_num_t coefficient_num
);

  typedef enum logic [3:0] {
    st_idle,
    st_load0,
    st_wait0,
    st_load1,
    st_wait1,
    st_load2,
    st_wait2,
    st_load3,
    st_wait3
  } state_t;

  state_t state, next_state;

  always_ff @(posedge clk, negedge n_reset) begin
    if (!n_reset) begin
      state <= st_idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      st_idle:  if (new_coefficient_set) next_state = st_load0;
      st_load0: next_state = st_wait0;
      st_wait0: if (!modwait) next_state = st_load1;
      st_load1: next_state = st_wait1;
      st_wait1: if (!modwait) next_state = st_load2;
      st_load2: next_state = st_wait2;
      st_wait2: if (!modwait) next_state = st_load3;
      st_load3: next_state = st_wait3;
      st_wait3: if (!modwait) next_state = st_idle;  // set done
      default:  next_state = st_idle;
    endcase
  end

  // moore outputs, number held through each wait
  always_comb begin
    load_coeff      = 1'b0;
    coefficient_num = 2'd0;
    case (state)
      st_load0: load_coeff = 1'b1;
      st_load1: begin
        load_coeff      = 1'b1;
        coefficient_num = 2'd1;
      end
      st_wait1: coefficient_num = 2'd1;
      st_load2: begin
        load_coeff      = 1'b1;
        coefficient_num = 2'd2;
      end
      st_wait2: coefficient_num = 2'd2;
      st_load3: begin
        load_coeff      = 1'b1;
        coefficient_num = 2'd3;
      end
      st_wait3: coefficient_num = 2'd3;
      default:  coefficient_num = 2'd0;
    endcase
  end

endmodule

// File: fir_controller.sv
/*
  Schedules coefficient loads and sample runs on the FIR datapath.
  A sample run takes shift, four MAC cycles and emit. Samples arriving while
  modwait is high are dropped and flagged on drop_err one cycle later.
  A load that arrives mid-run is remembered and served after the result.
  The loader must hold coefficient_num until modwait falls.
*/
module fir_controller (
  input  logic                      clk,
  input  logic                      n_reset,
  input  logic                      load_coeff,
  input  fir_types_pkg::coeff_num_t coefficient_num,
  input  fir_types_pkg::sample_in_t sample_in,
  output logic                      modwait,
  output fir_ctrl_pkg::dp_cmd_t     dp_cmd,
  output logic                      drop_err
);

  typedef enum logic [1:0] {
    st_idle,
    st_mac,
    st_emit,
    st_done
  } state_t;

  state_t                    state, next_state;
  fir_types_pkg::coeff_num_t tap_cnt;
  logic                      load_pending, next_load_pending;

  always_comb begin
    next_state        = state;
    next_load_pending = load_pending;
    dp_cmd.op         = fir_ctrl_pkg::op_idle;
    dp_cmd.tap        = tap_cnt;
    case (state)
      st_idle: begin
        if (sample_in.data_ready) begin
          dp_cmd.op         = fir_ctrl_pkg::op_shift;  // sample is taken this cycle
          next_state        = st_mac;
          next_load_pending = load_coeff;
        end else if (load_coeff) begin
          dp_cmd.op  = fir_ctrl_pkg::op_load;
          dp_cmd.tap = coefficient_num;
          next_state = st_done;
        end
      end
      st_mac: begin
        dp_cmd.op         = fir_ctrl_pkg::op_mac;
        next_load_pending = load_pending | load_coeff;
        if (tap_cnt == 2'd3) next_state = st_emit;
      end
      st_emit: begin
        dp_cmd.op         = fir_ctrl_pkg::op_emit;
        next_load_pending = load_pending | load_coeff;
        next_state        = st_done;
      end
      st_done: begin
        // serve a deferred load here, stay busy one more cycle
        if (load_pending || load_coeff) begin
          dp_cmd.op         = fir_ctrl_pkg::op_load;
          dp_cmd.tap        = coefficient_num;
          next_load_pending = 1'b0;
        end else begin
          next_state = st_idle;
        end
      end
      default: next_state = st_idle;
    endcase
  end

  always_ff @(posedge clk, negedge n_reset) begin
    if (!n_reset) begin
      state        <= st_idle;
      load_pending <= 1'b0;
      tap_cnt      <= '0;
      modwait      <= 1'b0;
      drop_err     <= 1'b0;
    end else begin
      state        <= next_state;
      load_pending <= next_load_pending;
      modwait      <= (next_state != st_idle);
      drop_err     <= sample_in.data_ready && modwait;  // busy, sample lost
      if (state == st_mac) begin
        tap_cnt <= tap_cnt + 2'd1;  // wraps to 0 after tap 3
      end else begin
        tap_cnt <= '0;
      end
    end
  end

endmodule

// File: fir_ctrl_pkg.sv
/*
  Command set between the FIR controller and its datapath.
  One command is presented every cycle. The datapath acts on it at the
  next rising edge.
  The tap index is only meaningful for load and MAC operations.
*/
package fir_ctrl_pkg;

  typedef enum logic [2:0] {
    op_idle,
    op_load,   // write coefficient at tap
    op_shift,  // push new sample, clear accumulator
    op_mac,    // acc += delay[tap] * coeff[tap]
    op_emit    // shift, saturate and register result
  } dp_op_t;

  typedef struct packed {
    dp_op_t                  op;
    fir_types_pkg::coeff_num_t tap;
  } dp_cmd_t;

endpackage

// File: fir_datapath.sv
/*
  Delay line, coefficient registers and a single multiply-accumulate unit.
  Tap 0 holds the newest sample. The output is the accumulator shifted right
  by COEFF_FRAC, which rounds toward minus infinity, then saturated to
  SAMPLE_W bits. The sample input is only sampled on a shift command.
*/
module fir_datapath (
  input  logic                                      clk,
  input  logic                                      n_reset,
  input  fir_ctrl_pkg::dp_cmd_t                     dp_cmd,
  input  logic signed [fir_types_pkg::COEFF_W-1:0]  coeff_value,
  input  logic signed [fir_types_pkg::SAMPLE_W-1:0] sample,
  output fir_types_pkg::fir_result_t                result
);

  localparam int SHIFT_W = fir_types_pkg::ACC_W - fir_types_pkg::COEFF_FRAC;

  logic signed [fir_types_pkg::SAMPLE_W-1:0] delay_line [fir_types_pkg::NUM_TAPS];
  logic signed [fir_types_pkg::COEFF_W-1:0]  coeffs     [fir_types_pkg::NUM_TAPS];
  logic signed [fir_types_pkg::ACC_W-1:0]    acc;
  logic signed [fir_types_pkg::SAMPLE_W+fir_types_pkg::COEFF_W-1:0] product;
  logic signed [SHIFT_W-1:0]                 acc_shift;
  logic [SHIFT_W-fir_types_pkg::SAMPLE_W:0]  upper_bits;
  logic                                      overflow;
  logic signed [fir_types_pkg::SAMPLE_W-1:0] sat_value;

  assign product   = delay_line[dp_cmd.tap] * coeffs[dp_cmd.tap];
  assign acc_shift = acc[fir_types_pkg::ACC_W-1:fir_types_pkg::COEFF_FRAC];  // floor

  // fits only if the sign bit and everything above it agree
  assign upper_bits = acc_shift[SHIFT_W-1:fir_types_pkg::SAMPLE_W-1];
  assign overflow   = !((&upper_bits) || !(|upper_bits));
  assign sat_value  = overflow ?
                      {acc_shift[SHIFT_W-1], {(fir_types_pkg::SAMPLE_W-1){~acc_shift[SHIFT_W-1]}}} :
                      acc_shift[fir_types_pkg::SAMPLE_W-1:0];

  always_ff @(posedge clk, negedge n_reset) begin
    if (!n_reset) begin
      for (int i = 0; i < fir_types_pkg::NUM_TAPS; i++) begin
        delay_line[i] <= '0;
        coeffs[i]     <= '0;
      end
      acc    <= '0;
      result <= '0;
    end else begin
      result.valid <= (dp_cmd.op == fir_ctrl_pkg::op_emit);
      case (dp_cmd.op)
        fir_ctrl_pkg::op_load: coeffs[dp_cmd.tap] <= coeff_value;
        fir_ctrl_pkg::op_shift: begin
          delay_line[0] <= sample;
          for (int i = 1; i < fir_types_pkg::NUM_TAPS; i++) begin
            delay_line[i] <= delay_line[i-1];
          end
          acc <= '0;
        end
        fir_ctrl_pkg::op_mac: acc <= acc + product;  // product sign-extends
        fir_ctrl_pkg::op_emit: begin
          result.data      <= sat_value;
          result.saturated <= overflow;
        end
        default: ;
      endcase
    end
  end

endmodule

// File: fir_filter.sv
/*
  Four-tap FIR filter top.
  Samples must be sent only while modwait is low, otherwise they are dropped
  and err pulses. err also pulses with any saturated result.
  Result valid follows an accepted data_ready by six cycles.
*/
module fir_filter (
  input  logic                         clk,
  input  logic                         n_reset,
  input  fir_types_pkg::coeff_write_t  host_write,
  input  logic                         new_coefficient_set,
  input  fir_types_pkg::sample_in_t    sample_in,
  output logic                         modwait,
  output fir_types_pkg::fir_result_t   result,
  output logic                         err
);

  logic                                     set_pending;
  logic                                     load_coeff;
  fir_types_pkg::coeff_num_t                coefficient_num;
  logic signed [fir_types_pkg::COEFF_W-1:0] coeff_value;
  fir_ctrl_pkg::dp_cmd_t                    dp_cmd;
  logic                                     drop_err;

  coeff_regs u_coeff_regs (
    .clk                 (clk),
    .n_reset             (n_reset),
    .host_write          (host_write),
    .new_coefficient_set (new_coefficient_set),
    .load_coeff          (load_coeff),
    .coefficient_num     (coefficient_num),
    .set_pending         (set_pending),
    .coeff_value         (coeff_value)
  );

  coefficient_loader u_loader (
    .clk                 (clk),
    .n_reset             (n_reset),
    .new_coefficient_set (set_pending),  // level from the bank
    .modwait             (modwait),
    .load_coeff          (load_coeff),
    .coefficient_num     (coefficient_num)
  );

  fir_controller u_controller (
    .clk             (clk),
    .n_reset         (n_reset),
    .load_coeff      (load_coeff),
    .coefficient_num (coefficient_num),
    .sample_in       (sample_in),
    .modwait         (modwait),
    .dp_cmd          (dp_cmd),
    .drop_err        (drop_err)
  );

  fir_datapath u_datapath (
    .clk         (clk),
    .n_reset     (n_reset),
    .dp_cmd      (dp_cmd),
    .coeff_value (coeff_value),
    .sample      (sample_in.sample),
    .result      (result)
  );

  assign err = drop_err | (result.valid & result.saturated);

endmodule

// File: fir_types_pkg.sv
/*
  Widths and shared data structs of the four-tap FIR core.
  The tap count is fixed at four because the coefficient index is two bits wide.
  Coefficients are Q1.15, so the accumulator is shifted right by COEFF_FRAC
  before it is saturated to the sample width.
*/
package fir_types_pkg;

  localparam int NUM_TAPS   = 4;
  localparam int SAMPLE_W   = 16;
  localparam int COEFF_W    = 16;
  localparam int COEFF_FRAC = 15;
  localparam int ACC_W      = 34;  // 32-bit products plus growth for four taps

  typedef logic [1:0] coeff_num_t;

  typedef struct packed {
    logic                      wr;     // write strobe, one cycle
    coeff_num_t                idx;
    logic signed [COEFF_W-1:0] value;
  } coeff_write_t;

  typedef struct packed {
    logic                       data_ready;  // one-cycle pulse
    logic signed [SAMPLE_W-1:0] sample;
  } sample_in_t;

  typedef struct packed {
    logic                       valid;
    logic signed [SAMPLE_W-1:0] data;
    logic                       saturated;
  } fir_result_t;

endpackage

// File: project.f
fir_types_pkg.sv
fir_ctrl_pkg.sv
coefficient_loader.sv
coeff_regs.sv
fir_controller.sv
fir_datapath.sv
fir_filter.sv
tb_fir_filter.sv

// File: tb_fir_filter.sv
/*
  Random testbench for the four-tap FIR filter.
  Samples are only offered while modwait is low, except the one sample that
  is sent on purpose into a busy filter to check the drop error.
  The model takes on a new coefficient set once modwait has stayed low.
*/
module tb_fir_filter;
  timeunit 1ns;
  timeprecision 100ps;

  logic                        clk;
  logic                        n_reset;
  fir_types_pkg::coeff_write_t host_write;
  logic                        new_coefficient_set;
  fir_types_pkg::sample_in_t   sample_in;
  logic                        modwait;
  fir_types_pkg::fir_result_t  result;
  logic                        err;

  int seed = 32'h0bbb_b5bd;
  logic signed [fir_types_pkg::SAMPLE_W-1:0] mdl_delay [fir_types_pkg::NUM_TAPS];
  logic signed [fir_types_pkg::COEFF_W-1:0]  mdl_coef  [fir_types_pkg::NUM_TAPS];
  logic signed [fir_types_pkg::COEFF_W-1:0]  next_coef [fir_types_pkg::NUM_TAPS];

  fir_filter dut (
    .clk                 (clk),
    .n_reset             (n_reset),
    .host_write          (host_write),
    .new_coefficient_set (new_coefficient_set),
    .sample_in           (sample_in),
    .modwait             (modwait),
    .result              (result),
    .err                 (err)
  );

  always #10 clk = ~clk;

  task automatic flag_mismatch(input string msg);
    $display("ERROR at time %0t: %s", $time, msg);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic abort_on_timeout(input string msg);
    $display("Timeout: %s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;  // drive point
  endtask

  // sum of products over the delay line, floor shift, clamp to 16 bits
  function automatic void expect_result(output logic signed [15:0] data, output logic sat);
    longint acc;
    acc = 0;
    for (int i = 0; i < fir_types_pkg::NUM_TAPS; i++) begin
      acc += longint'(mdl_delay[i]) * longint'(mdl_coef[i]);
    end
    acc = acc >>> fir_types_pkg::COEFF_FRAC;
    sat = (acc > 32767) || (acc < -32768);
    if (acc > 32767) data = 16'sh7fff;
    else if (acc < -32768) data = 16'sh8000;
    else data = acc[15:0];
  endfunction

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (modwait) begin
      next_cycle();
      cycles++;
      if (cycles > 50) abort_on_timeout("modwait stayed high for more than 50 cycles");
    end
  endtask

  // loads leave short gaps in modwait, so wait for a longer quiet run
  task automatic wait_quiet();
    int low_run;
    int cycles;
    low_run = 0;
    cycles  = 0;
    while (low_run < 4) begin
      next_cycle();
      cycles++;
      low_run = modwait ? 0 : low_run + 1;
      if (cycles > 200) abort_on_timeout("coefficient set was not loaded within 200 cycles");
    end
  endtask

  task automatic write_bank(input int range);
    for (int i = 0; i < fir_types_pkg::NUM_TAPS; i++) begin
      next_coef[i]     = (range == 0) ? 16'sh7fff : $random(seed) % range;
      host_write.wr    = 1'b1;
      host_write.idx   = fir_types_pkg::coeff_num_t'(i);
      host_write.value = next_coef[i];
      next_cycle();
    end
    host_write = '0;
  endtask

  task automatic commit_coefs();
    for (int i = 0; i < fir_types_pkg::NUM_TAPS; i++) mdl_coef[i] = next_coef[i];
  endtask

  task automatic pulse_new_set();
    new_coefficient_set = 1'b1;
    next_cycle();
    new_coefficient_set = 1'b0;
  endtask

  // one accepted sample, optionally a set request or a busy sample during the run
  task automatic run_sample(input logic signed [15:0] value, input bit mid_set, input bit mid_drop);
    int cycles;
    logic signed [15:0] exp_data;
    logic exp_sat;
    wait_idle();
    sample_in.data_ready = 1'b1;
    sample_in.sample     = value;
    for (int i = fir_types_pkg::NUM_TAPS - 1; i > 0; i--) mdl_delay[i] = mdl_delay[i-1];
    mdl_delay[0] = value;
    expect_result(exp_data, exp_sat);
    cycles = 0;
    do begin
      next_cycle();
      cycles++;
      sample_in.data_ready = mid_drop && (cycles == 2);  // lands while busy
      sample_in.sample     = $random(seed);
      new_coefficient_set  = mid_set && (cycles == 2);
      if (mid_drop && cycles == 3) begin
        assert (err) else flag_mismatch("err not raised for a sample sent while busy");
      end
      if (cycles > 20) abort_on_timeout("no result valid within 20 cycles of data_ready");
    end while (!result.valid);
    assert (cycles == 6)
      else flag_mismatch($sformatf("result valid %0d cycles after data_ready", cycles));
    assert (result.data == exp_data)
      else flag_mismatch($sformatf("result %0d, expected %0d", result.data, exp_data));
    assert (result.saturated == exp_sat)
      else flag_mismatch($sformatf("saturation flag %0b, expected %0b", result.saturated, exp_sat));
    assert (err == exp_sat) else flag_mismatch($sformatf("err %0b, expected %0b", err, exp_sat));
  endtask

  initial begin
    clk                 = 1'b0;
    n_reset             = 1'b0;
    host_write          = '0;
    new_coefficient_set = 1'b0;
    sample_in           = '0;
    for (int i = 0; i < fir_types_pkg::NUM_TAPS; i++) begin
      mdl_delay[i] = '0;
      mdl_coef[i]  = '0;
    end
    repeat (5) @(posedge clk);
    #2;
    n_reset = 1'b1;
    assert (!modwait && !result.valid && !err) else flag_mismatch("outputs not idle after reset");
    run_sample($random(seed), 0, 0);  // zero coefficients give 0

    write_bank(8192);
    pulse_new_set();
    wait_quiet();
    commit_coefs();
    repeat (40) run_sample($random(seed), 0, 0);

    // full-scale taps and samples clip both ways
    write_bank(0);
    pulse_new_set();
    wait_quiet();
    commit_coefs();
    repeat (4) run_sample(16'sh7fff, 0, 0);
    assert (result.saturated && result.data == 16'sh7fff)
      else flag_mismatch("positive full scale did not saturate");
    repeat (4) run_sample(16'sh8000, 0, 0);
    assert (result.saturated && result.data == 16'sh8000)
      else flag_mismatch("negative full scale did not saturate");

    write_bank(8192);
    pulse_new_set();
    wait_quiet();
    commit_coefs();
    run_sample($random(seed), 0, 1);
    run_sample($random(seed), 0, 0);

    // set requested mid run, old taps still apply to that run
    write_bank(8192);
    run_sample($random(seed), 1, 0);
    wait_quiet();
    commit_coefs();
    repeat (10) run_sample($random(seed), 0, 0);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule
